//--- dv/decodeStage_assert.sv
module decodeStageAssert #(
	parameter int QueueDepth = 4,
	parameter int ConsumerCredits = 4
) (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input logic decCredit,
	input logic decValid,
	input logic instrCredit
);

timeunit 1ns;
timeprecision 1ps;

// Shadow copies of the output credit counter and the queue occupancy
int credits;
int occupancy;

always_ff @(posedge clk)
begin
	if (rst)
	begin
		credits <= ConsumerCredits;
		occupancy <= 0;
	end
	else
	begin
		credits <= credits - int'(decValid) + int'(decCredit);
		occupancy <= occupancy + int'(instrValid) - int'(decValid);
	end
end

// Rename must hold a credit for every bundle it receives
creditHeld: assert property (@(posedge clk) disable iff (rst) decValid |-> credits > 0)
	else $error("decValid fired with no output credit left");

// Fetch may only send while the queue has a free slot
roomInQueue: assert property (@(posedge clk) disable iff (rst)
	instrValid |-> occupancy < QueueDepth)
	else $error("instrValid arrived while the decode queue was full");

quietAfterReset: assert property (@(posedge clk) rst |=> !decValid && !instrCredit)
	else $error("decValid or instrCredit high in the cycle after reset");

endmodule

bind decodeStage decodeStageAssert #(
	.QueueDepth(QueueDepth),
	.ConsumerCredits(ConsumerCredits)
) creditChecks (
	.clk(clk),
	.rst(rst),
	.instrValid(instrValid),
	.decCredit(decCredit),
	.decValid(decValid),
	.instrCredit(instrCredit)
);

//--- dv/decodeRefModel.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// Expected bundle for one instruction word, in the order rename sees it
typedef struct packed {
	decodePkg::aregNoT rs1;
	decodePkg::aregNoT rs2;
	decodePkg::aregNoT rs3;
	logic              rs1z;
	logic              rs2z;
	logic              rs3z;
	logic              hasConst;
	logic [63:0]       constVal;
} bundleT;

// The nine store forms, which read their data register from bits 11..7
function automatic logic storeOpcode(input logic [6:0] op);
	case (op)
	decodePkg::OpStb, decodePkg::OpStbi, decodePkg::OpStw, decodePkg::OpStwi,
	decodePkg::OpStt, decodePkg::OpStti, decodePkg::OpStore, decodePkg::OpStorei,
	decodePkg::OpStptr:
		return 1'b1;
	default:
		return 1'b0;
	endcase
endfunction

// Works straight from bit positions of the word
function automatic bundleT decodeRef(input logic [31:0] word, input logic [1:0] mode);
	bundleT b;
	logic [6:0] op;
	logic store;
	decodePkg::aregNoT third;
	op = word[6:0];
	store = storeOpcode(op);
	b.rs1 = {2'b00, word[16:12]};
	b.rs2 = {2'b00, word[21:17]};
	third = store ? {2'b00, word[11:7]} : 7'd0;
	// MOVEA reads the stack pointer of the current mode
	if (op == decodePkg::OpMov && word[28:26] != 3'd1 && word[11:7] == 5'd31)
		third = 7'd64 + {5'd0, mode};
	b.hasConst = word[31] && (op != decodePkg::OpMov);
	if (!b.hasConst)
		b.constVal = 64'd0;
	else if (store)
		b.constVal = {{57{word[31]}}, word[31:25]};
	else
		b.constVal = {{52{word[28]}}, word[28:17]};
	// A constant takes the third source slot
	b.rs3 = b.hasConst ? 7'd0 : third;
	b.rs1z = (b.rs1 == 7'd0);
	b.rs2z = (b.rs2 == 7'd0);
	b.rs3z = (b.rs3 == 7'd0);
	return b;
endfunction

`endif

//--- dv/decodeTb.sv
module decodeTb;

timeunit 1ns;
timeprecision 1ps;

localparam int QueueDepth = 4;
localparam int ConsumerCredits = 4;
localparam int ClkPeriod = 100;
localparam int NumStore = 18;
localparam int NumMovea = 8;
localparam int NumConst = 24;
localparam int NumRandom = 200;
localparam int NumStall = 60;
localparam int TotalWords = NumStore + NumMovea + NumConst + NumRandom + NumStall;

localparam decodePkg::opcodeT StoreOps [9] = '{decodePkg::OpStb, decodePkg::OpStbi,
	decodePkg::OpStw, decodePkg::OpStwi, decodePkg::OpStt, decodePkg::OpStti,
	decodePkg::OpStore, decodePkg::OpStorei, decodePkg::OpStptr};

logic clk;
logic rst;
logic instrValid;
decodePkg::instrT instr;
decodePkg::operatingModeT om;
logic instrCredit;
logic decCredit;
logic decValid;
decodePkg::aregNoT rs1;
decodePkg::aregNoT rs2;
decodePkg::aregNoT rs3;
logic rs1z;
logic rs2z;
logic rs3z;
logic hasConst;
logic [63:0] constVal;

`include "decodeRefModel.svh"

// Words in flight, oldest first, with the mode each was sent in
logic [31:0] expWords [$];
logic [1:0] expModes [$];
int fetchCredits;
// Output credits that the decode stage should hold toward rename
int renameCredits;
// Credits that rename still has to hand back
int owed;
logic stallMode;

decodeStage #(
	.QueueDepth(QueueDepth),
	.ConsumerCredits(ConsumerCredits)
) UUT (
	.clk(clk),
	.rst(rst),
	.instrValid(instrValid),
	.instr(instr),
	.om(om),
	.instrCredit(instrCredit),
	.decCredit(decCredit),
	.decValid(decValid),
	.rs1(rs1),
	.rs2(rs2),
	.rs3(rs3),
	.rs1z(rs1z),
	.rs2z(rs2z),
	.rs3z(rs3z),
	.hasConst(hasConst),
	.constVal(constVal)
);

always #(ClkPeriod / 2) clk = ~clk;

// ========================================
// Check helpers
// ========================================

task automatic failRun();
	$display("Checks failed");
	$fatal(1, "Run stopped at the first error");
endtask

task automatic compareReg(input string name, input decodePkg::aregNoT got,
	input decodePkg::aregNoT want);
	if (got !== want)
	begin
		$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, want);
		failRun();
	end
endtask

task automatic compareBit(input string name, input logic got, input logic want);
	if (got !== want)
	begin
		$display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, want);
		failRun();
	end
endtask

task automatic compareConst(input string name, input logic [63:0] got, input logic [63:0] want);
	if (got !== want)
	begin
		$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
		failRun();
	end
endtask

// Waits for a fetch credit, then presents the word for one cycle
task automatic sendWord(input logic [31:0] word, input logic [1:0] mode);
	@(posedge clk);
	while (fetchCredits == 0)
	begin
		instrValid <= 1'b0;
		@(posedge clk);
	end
	instrValid <= 1'b1;
	instr <= word;
	om <= decodePkg::operatingModeT'(mode);
	expWords.push_back(word);
	expModes.push_back(mode);
endtask

// ========================================
// Credit model and compare process
// ========================================

// Sampled mid-cycle, where every DUT output has settled
always @(negedge clk)
begin
	bundleT want;
	logic expPop;
	if (!rst)
	begin
		// A bundle leaves whenever one is queued and rename holds a credit
		// The word presented in this cycle only enters the queue at the next edge
		expPop = (expWords.size() > int'(instrValid)) && (renameCredits > 0);
		compareBit("decValid", decValid, expPop);
		// The freed slot goes back to fetch in the cycle the bundle leaves
		compareBit("instrCredit", instrCredit, expPop);
		if (instrValid)
			fetchCredits--;
		if (instrCredit)
			fetchCredits++;
		renameCredits = renameCredits - int'(expPop) + int'(decCredit);
		if (expPop)
		begin
			want = decodeRef(expWords.pop_front(), expModes.pop_front());
			owed++;
			compareReg("rs1", rs1, want.rs1);
			compareReg("rs2", rs2, want.rs2);
			compareReg("rs3", rs3, want.rs3);
			compareBit("rs1z", rs1z, want.rs1z);
			compareBit("rs2z", rs2z, want.rs2z);
			compareBit("rs3z", rs3z, want.rs3z);
			compareBit("hasConst", hasConst, want.hasConst);
			compareConst("constVal", constVal, want.constVal);
		end
	end
end

// Rename hands back one credit per bundle, after a short or a long wait
initial
begin
	int delay;
	forever
	begin
		@(posedge clk);
		decCredit <= 1'b0;
		if (owed > 0)
		begin
			delay = stallMode ? $urandom_range(30, 8) : $urandom_range(3, 0);
			repeat (delay) @(posedge clk);
			decCredit <= 1'b1;
			owed--;
		end
	end
end

initial
begin
	#((TotalWords * 40 + 200) * ClkPeriod);
	$display("Timeout: the decode stage did not drain all %0d words in time", TotalWords);
	failRun();
end

// ========================================
// Stimulus
// ========================================

initial
begin
	logic [31:0] word;
	void'($urandom(32'h097dafb2));
	clk = 1'b0;
	rst = 1'b1;
	instrValid = 1'b0;
	instr = '0;
	om = decodePkg::OmUser;
	decCredit = 1'b0;
	fetchCredits = QueueDepth;
	renameCredits = ConsumerCredits;
	owed = 0;
	stallMode = 1'b0;
	repeat (3) @(posedge clk);
	rst <= 1'b0;

	// Every store form without a constant, first with Rsd zero
	for (int i = 0; i < NumStore; i++)
	begin
		word = $urandom;
		word[6:0] = StoreOps[i % 9];
		word[31] = 1'b0;
		if (i < 9)
			word[11:7] = 5'd0;
		sendWord(word, 2'($urandom_range(3, 0)));
	end

	// MOVEA in all four modes, then the plain MOV form that never aliases
	for (int i = 0; i < NumMovea; i++)
	begin
		word = $urandom;
		word[6:0] = decodePkg::OpMov;
		word[11:7] = 5'd31;
		word[28:26] = (i < 4) ? 3'(i * 2) : 3'd1;
		sendWord(word, 2'(i % 4));
	end

	// Constants, alternating store and other forms
	for (int i = 0; i < NumConst; i++)
	begin
		word = $urandom;
		word[31] = 1'b1;
		if (i % 2 == 0)
			word[6:0] = StoreOps[(i / 2) % 9];
		else if (word[6:0] == decodePkg::OpMov)
			word[6:0] = decodePkg::OpAddi;
		sendWord(word, 2'($urandom_range(3, 0)));
	end

	for (int i = 0; i < NumRandom; i++)
		sendWord($urandom, 2'($urandom_range(3, 0)));

	// Long credit stalls from rename
	@(negedge clk);
	stallMode = 1'b1;
	for (int i = 0; i < NumStall; i++)
		sendWord($urandom, 2'($urandom_range(3, 0)));
	@(posedge clk);
	instrValid <= 1'b0;
	@(negedge clk);
	stallMode = 1'b0;

	// Quiet cycles after the drain catch any extra bundle
	while (expWords.size() != 0)
		@(posedge clk);
	repeat (10) @(posedge clk);
	$display("All checks passed");
	$finish;
end

endmodule

//--- hdl/constDecode.sv
module constDecode (
	input  decodePkg::instrT instr,
	output logic             hasConst,
	output logic [63:0]      constVal
);

// ========================================
// Constant detection
// ========================================

// The top cbits bit flags a constant operand
// MOV reuses that bit for its own purpose and never carries a constant
logic constFlag;
logic isMov;

always_comb
begin
	constFlag = instr.anyFmt.cbits[2];
	isMov = (instr.anyFmt.opcode == decodePkg::OpMov);
	hasConst = constFlag && !isMov;
end

// ========================================
// Constant value
// ========================================

// Stores keep their data register in Rsd, so only the 7-bit
// displacement at the top of the scaled layout is left for a constant
logic [6:0] shortImm;

// Other forms take a 12-bit field spanning sub, func and the Rs2 slot
// (bits 28..17 of the word)
logic [11:0] longImm;

// Which of the two widths applies to this word
logic storeForm;

always_comb
begin
	shortImm = instr.lsscnFmt.disp;
	longImm = {instr.anyFmt.sub, instr.anyFmt.func, instr.anyFmt.rs2};
	storeForm = decodePkg::isStoreOp(instr.lsscnFmt.opcode);
end

// Both forms are sign extended to the full 64-bit datapath width
// A word without a constant drives zero so the bundle stays clean
always_comb
begin
	if (!hasConst)
		constVal = '0;
	else if (storeForm)
		constVal = {{57{shortImm[6]}}, shortImm};
	else
		constVal = {{52{longImm[11]}}, longImm};
end

endmodule

//--- hdl/decodeMerge.sv
module decodeMerge #(
	parameter int QueueDepth = 4,
	parameter int ConsumerCredits = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              instrValid,
	input  logic              decCredit,
	input  decodePkg::aregNoT rs1,
	input  decodePkg::aregNoT rs2,
	input  decodePkg::aregNoT rs3Raw,
	input  logic              hasConstIn,
	input  logic [63:0]       constValIn,
	output logic              instrCredit,
	output logic              decValid,
	output decodePkg::aregNoT rs1Out,
	output decodePkg::aregNoT rs2Out,
	output decodePkg::aregNoT rs3,
	output logic              rs1z,
	output logic              rs2z,
	output logic              rs3z,
	output logic              hasConst,
	output logic [63:0]       constVal
);

// Pointer, occupancy and credit counter widths
localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
localparam int CntW = $clog2(QueueDepth + 1);
localparam int CredW = $clog2(ConsumerCredits + 1);

// ========================================
// Merge of the two decoders
// ========================================

// A constant occupies the third operand slot, so Rs3 is dropped
decodePkg::aregNoT rs3Eff;

// Zero flags packed as {rs3z, rs2z, rs1z}
logic [2:0] zeroIn;

always_comb
begin
	rs3Eff = hasConstIn ? '0 : rs3Raw;
	zeroIn = {rs3Eff == '0, rs2 == '0, rs1 == '0};
end

// ========================================
// In-order output queue
// ========================================

decodePkg::aregNoT qRs1 [QueueDepth];
decodePkg::aregNoT qRs2 [QueueDepth];
decodePkg::aregNoT qRs3 [QueueDepth];
logic [2:0] qZero [QueueDepth];
logic qHasConst [QueueDepth];
logic [63:0] qConst [QueueDepth];

logic [PtrW-1:0] wrPtr;
logic [PtrW-1:0] rdPtr;
logic [CntW-1:0] count;

// Credits still held toward rename
logic [CredW-1:0] outCredits;

logic push;
logic pop;

// Wrap at the queue depth, which need not be a power of two
function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] p);
	if (p == PtrW'(QueueDepth - 1))
		return '0;
	else
		return p + 1'b1;
endfunction

// Fetch only sends while it holds a credit, so a push always finds room
assign push = instrValid;
// One entry leaves per cycle whenever rename can take it
assign pop = (count != '0) && (outCredits != '0);

// Payload storage
always_ff @(posedge clk)
begin
	if (push)
	begin
		qRs1[wrPtr] <= rs1;
		qRs2[wrPtr] <= rs2;
		qRs3[wrPtr] <= rs3Eff;
		qZero[wrPtr] <= zeroIn;
		qHasConst[wrPtr] <= hasConstIn;
		qConst[wrPtr] <= constValIn;
	end
end

// Pointers, occupancy and the output credit counter
// A pop and a returned credit in the same cycle cancel out
always_ff @(posedge clk)
begin
	if (rst)
	begin
		wrPtr <= '0;
		rdPtr <= '0;
		count <= '0;
		outCredits <= CredW'(ConsumerCredits);
	end
	else
	begin
		if (push)
			wrPtr <= nextPtr(wrPtr);
		if (pop)
			rdPtr <= nextPtr(rdPtr);
		count <= count + CntW'(push) - CntW'(pop);
		outCredits <= outCredits - CredW'(pop) + CredW'(decCredit);
	end
end

// ========================================
// Bundle toward rename
// ========================================

// The head entry is presented in the cycle it leaves the queue, and the
// freed slot goes back to fetch as a credit in that same cycle
always_comb
begin
	decValid = pop;
	instrCredit = pop;
	rs1Out = qRs1[rdPtr];
	rs2Out = qRs2[rdPtr];
	rs3 = qRs3[rdPtr];
	{rs3z, rs2z, rs1z} = qZero[rdPtr];
	hasConst = qHasConst[rdPtr];
	constVal = qConst[rdPtr];
end

endmodule

//--- hdl/decodePkg.sv
package decodePkg;

// ========================================
// Opcodes
// ========================================

// Only the opcodes that the register and constant decoders treat
// specially get a name; any other 7-bit value decodes as generic
typedef enum logic [6:0] {
	OpAdd    = 7'd4,
	OpAddi   = 7'd5,
	OpMov    = 7'd8,
	OpStb    = 7'd80,
	OpStbi   = 7'd81,
	OpStw    = 7'd82,
	OpStwi   = 7'd83,
	OpStt    = 7'd84,
	OpStti   = 7'd85,
	OpStore  = 7'd86,
	OpStorei = 7'd87,
	OpStptr  = 7'd88
} opcodeT;

// Privilege level of the hart, which also selects the stack pointer
typedef enum logic [1:0] {
	OmUser       = 2'd0,
	OmSupervisor = 2'd1,
	OmHypervisor = 2'd2,
	OmMachine    = 2'd3
} operatingModeT;

// Architectural register number
// 0..31 are the general registers, 64..67 the per-mode stack pointers
typedef logic [6:0] aregNoT;

// First stack pointer slot; the mode is added on top of it
localparam aregNoT StackPtrBase = 7'd64;

// A MOV whose Rd is this register reads the stack pointer (MOVEA)
localparam logic [4:0] MoveaRd = 5'd31;

// MOV sub-function that never takes the stack alias
localparam logic [2:0] MovSubNoAlias = 3'd1;

// ========================================
// Instruction word
// ========================================

// The same 32 bits read as the general layout or as the scaled
// load/store layout, depending on the opcode
typedef union packed {
	struct packed {
		logic [2:0] cbits;
		logic [2:0] sub;
		logic [3:0] func;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [4:0] rd;
		opcodeT     opcode;
	} anyFmt;
	struct packed {
		logic [6:0] disp;
		logic [2:0] scale;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [4:0] rsd;
		opcodeT     opcode;
	} lsscnFmt;
} instrT;

// True for every store form; a store reads its data register as Rs3
// and carries a short displacement as its constant
function automatic logic isStoreOp(input opcodeT op);
	case (op)
	OpStb, OpStbi, OpStw, OpStwi, OpStt, OpStti, OpStore, OpStorei, OpStptr:
		return 1'b1;
	default:
		return 1'b0;
	endcase
endfunction

endpackage

//--- hdl/decodeStage.sv
module decodeStage #(
	parameter int QueueDepth = 4,
	parameter int ConsumerCredits = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     instrValid,
	input  decodePkg::instrT         instr,
	input  decodePkg::operatingModeT om,
	output logic                     instrCredit,
	input  logic                     decCredit,
	output logic                     decValid,
	output decodePkg::aregNoT        rs1,
	output decodePkg::aregNoT        rs2,
	output decodePkg::aregNoT        rs3,
	output logic                     rs1z,
	output logic                     rs2z,
	output logic                     rs3z,
	output logic                     hasConst,
	output logic [63:0]              constVal
);

// Raw results of the two decoders, both taken from the same word
decodePkg::aregNoT decRs1;
decodePkg::aregNoT decRs2;
decodePkg::aregNoT decRs3Raw;
logic decHasConst;
logic [63:0] decConstVal;

// Register fields, with the MOVEA stack alias folded into Rs3
regFieldDecode regDec (
	.instr(instr),
	.om(om),
	.rs1(decRs1),
	.rs2(decRs2),
	.rs3Raw(decRs3Raw)
);

// Constant flag and sign-extended value
constDecode constDec (
	.instr(instr),
	.hasConst(decHasConst),
	.constVal(decConstVal)
);

// Combines the results and queues the bundle under credit flow control
decodeMerge #(
	.QueueDepth(QueueDepth),
	.ConsumerCredits(ConsumerCredits)
) merge (
	.clk(clk),
	.rst(rst),
	.instrValid(instrValid),
	.decCredit(decCredit),
	.rs1(decRs1),
	.rs2(decRs2),
	.rs3Raw(decRs3Raw),
	.hasConstIn(decHasConst),
	.constValIn(decConstVal),
	.instrCredit(instrCredit),
	.decValid(decValid),
	.rs1Out(rs1),
	.rs2Out(rs2),
	.rs3(rs3),
	.rs1z(rs1z),
	.rs2z(rs2z),
	.rs3z(rs3z),
	.hasConst(hasConst),
	.constVal(constVal)
);

endmodule

//--- hdl/regFieldDecode.sv
module regFieldDecode (
	input  decodePkg::instrT         instr,
	input  decodePkg::operatingModeT om,
	output decodePkg::aregNoT        rs1,
	output decodePkg::aregNoT        rs2,
	output decodePkg::aregNoT        rs3Raw
);

// ========================================
// First and second sources
// ========================================

// Rs1 and Rs2 sit in the same place in both layouts, so the general
// layout is read for them; the upper bits stay clear because these
// fields can only name a general register
always_comb
begin
	rs1 = {2'b00, instr.anyFmt.rs1};
	rs2 = {2'b00, instr.anyFmt.rs2};
end

// ========================================
// Third source
// ========================================

// Set when the word is a MOV that reads a stack pointer through Rd=31
logic isMovea;

// Stack pointer register of the current mode
decodePkg::aregNoT modeSp;

// Store data register from the scaled layout, before any alias
decodePkg::aregNoT storeRs3;

// The store data register lives in the Rsd field of the scaled
// load/store layout
// Non-store words have no third register operand here
function automatic decodePkg::aregNoT fnStoreRs3(input decodePkg::instrT ir);
	if (decodePkg::isStoreOp(ir.lsscnFmt.opcode))
		return {2'b00, ir.lsscnFmt.rsd};
	else
		return '0;
endfunction

always_comb
begin
	// MOVEA is MOV with Rd=31 and any sub-function other than the plain one
	isMovea = (instr.anyFmt.opcode == decodePkg::OpMov)
		&& (instr.anyFmt.sub != decodePkg::MovSubNoAlias)
		&& (instr.anyFmt.rd == decodePkg::MoveaRd);
end

// Each mode has its own stack pointer, stacked above the base slot
always_comb
begin
	modeSp = decodePkg::StackPtrBase + {5'b00000, om};
end

always_comb
begin
	storeRs3 = fnStoreRs3(instr);
end

// MOV is not a store, so the alias never collides with a store source
always_comb
begin
	if (isMovea)
		rs3Raw = modeSp;
	else
		rs3Raw = storeRs3;
end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f tb.f --top-module decodeTb -o decodeSim > build.log 2>&1 \
	&& ./obj_dir/decodeSim > sim.log 2>&1 \
	|| echo "Build or simulation ended early, see build.log and sim.log" >> sim.log
cat sim.log

# A run that stops before the end never reaches the pass line
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All checks passed" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"

//--- tb.f
+incdir+dv
hdl/decodePkg.sv
hdl/regFieldDecode.sv
hdl/constDecode.sv
hdl/decodeMerge.sv
hdl/decodeStage.sv
dv/decodeStage_assert.sv
dv/decodeTb.sv
